//--- tb.f
+incdir+.
execPkg.sv
registerFile.sv
aluUnit.sv
serialShifter.sv
shiftCounter.sv
opSequencer.sv
execUnitTop.sv
tb_execUnit.sv

//--- Makefile
# Verilator simulation of the execution unit testbench

VERILATOR ?= verilator
TOP ?= tb_execUnit
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= All checks passed
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: run clean

# pass or fail comes from the log, not from the simulator exit code
run:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_execUnit.sv
`timescale 1ns/1ps
`include "regfile_defs.svh"
`default_nettype none

module tb_execUnit;

  import execPkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int RESET_CYCLES = 5;
  localparam int NUM_RANDOM = 300;
  // reset readback, LDI/ADD pairs, negative load, both shifts by every amount, r0 pair
  localparam int NUM_DIRECTED = `REG_COUNT + 2 * (`REG_COUNT - 1) + 1 + 2 * `REG_COUNT + 2;
  localparam int CYCLES_PER_CMD = 40;
  localparam int CYCLE_LIMIT = (NUM_RANDOM + NUM_DIRECTED) * CYCLES_PER_CMD + RESET_CYCLES;

  logic                 clk;
  logic                 rstN;
  logic                 req;
  opCodeT               opCode;
  logic [`REG_AW-1:0]   dstReg;
  logic [`REG_AW-1:0]   srcReg1;
  logic [`REG_AW-1:0]   srcReg2;
  logic [`DATA_W-1:0]   imm;
  logic                 ack;
  logic [`DATA_W-1:0]   result;

  logic [`DATA_W-1:0] regModel [0:`REG_COUNT-1];
  logic [31:0] lfsrState;
  int errCount;
  int cmdCount;
  int cycleCount = 0;

  execUnitTop dut_i (
    .clk(clk), .rstN(rstN), .req(req), .opCode(opCode), .dstReg(dstReg),
    .srcReg1(srcReg1), .srcReg2(srcReg2), .imm(imm), .ack(ack), .result(result)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  // names the sequencer state when the run hangs
  function automatic string stateName(input logic [2:0] st);
    case (st)
      3'd0: return "IDLE";
      3'd1: return "EXEC";
      3'd2: return "LOAD";
      3'd3: return "SHIFT";
      3'd4: return "WRITE";
      3'd5: return "ACK";
      default: return "UNKNOWN";
    endcase
  endfunction

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= CYCLE_LIMIT) begin
      $display("run timed out after %0d cycles with the sequencer in %s",
               cycleCount, stateName(dut_i.seq_i.state));
      $display("Checks failed");
      $finish;
    end
  end

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic takeBits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrStep(lfsrState);
      val = {val[30:0], lfsrState[0]};
    end
  endtask

  function automatic logic [`DATA_W-1:0] expectedResult(input opCodeT op,
      input logic [`DATA_W-1:0] a, input logic [`DATA_W-1:0] b,
      input logic [`DATA_W-1:0] immV);
    case (op)
      ADD: return a + b;
      SUB: return a - b;
      AND: return a & b;
      OR: return a | b;
      XOR: return a ^ b;
      LDI: return immV;
      SLL: return a << immV[`SHAMT_W-1:0];
      default: return $signed(a) >>> immV[`SHAMT_W-1:0];
    endcase
  endfunction

  task automatic reportError(input string msg);
    errCount++;
    $display("[ERROR] %0t: %s", $time, msg);
  endtask

  // called on a falling edge with ack low
  task automatic runCommand(input opCodeT op, input logic [`REG_AW-1:0] dst,
      input logic [`REG_AW-1:0] s1, input logic [`REG_AW-1:0] s2,
      input logic [`DATA_W-1:0] immV, input int extraWaits);
    logic [`DATA_W-1:0] expected;
    int latency;
    expected = expectedResult(op, regModel[s1], regModel[s2], immV);
    opCode = op;
    dstReg = dst;
    srcReg1 = s1;
    srcReg2 = s2;
    imm = immV;
    req = 1'b1;
    // req is sampled at the next rising edge, latency counts edges after it
    @(negedge clk);
    latency = 0;
    while (!ack) begin
      @(negedge clk);
      latency++;
    end
    cmdCount++;
    if ((op != SLL) && (op != SRA)) begin
      assert (latency == 2)
        else reportError($sformatf("%s ack latency %0d, expected 2", op.name(), latency));
    end
    assert (result == expected)
      else reportError($sformatf("%s r%0d r%0d imm %h gave %h, expected %h",
                                 op.name(), s1, s2, immV, result, expected));
    if (dst != '0) begin
      regModel[dst] = expected;
    end
    // requester holds req, result must not move
    for (int k = 0; k < extraWaits; k++) begin
      @(negedge clk);
      assert (ack && (result == expected))
        else reportError($sformatf("ack %b result %h during hold, expected %h",
                                   ack, result, expected));
    end
    req = 1'b0;
    @(negedge clk);
    assert (!ack)
      else reportError("ack still high one cycle after req fell");
  endtask

  initial begin
    logic [31:0] bits;
    logic [31:0] fields;
    opCodeT op;
    lfsrState = 32'hbf3a_616a;
    errCount = 0;
    cmdCount = 0;
    rstN = 1'b0;
    req = 1'b0;
    opCode = ADD;
    dstReg = '0;
    srcReg1 = '0;
    srcReg2 = '0;
    imm = '0;
    for (int i = 0; i < `REG_COUNT; i++) begin
      regModel[i] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    assert (!ack && (result == '0))
      else reportError($sformatf("after reset ack %b result %h", ack, result));

    // every register reads zero after reset
    for (int r = 0; r < `REG_COUNT; r++) begin
      runCommand(ADD, '0, r[`REG_AW-1:0], '0, '0, 0);
    end

    // LDI then ADD with r0 returns the immediate
    for (int r = 1; r < `REG_COUNT; r++) begin
      takeBits(`DATA_W, bits);
      runCommand(LDI, r[`REG_AW-1:0], '0, '0, bits[`DATA_W-1:0], 0);
      runCommand(ADD, r[`REG_AW-1:0], r[`REG_AW-1:0], '0, '0, 0);
    end

    // r1 negative so SRA has a sign to copy
    takeBits(`DATA_W, bits);
    bits = bits | 32'h8000;
    runCommand(LDI, 4'd1, '0, '0, bits[`DATA_W-1:0], 0);
    for (int amt = 0; amt < 16; amt++) begin
      takeBits(`REG_AW, fields);
      runCommand(SLL, '0, fields[`REG_AW-1:0], '0, amt[`DATA_W-1:0], 0);
      runCommand(SRA, '0, 4'd1, '0, amt[`DATA_W-1:0], 0);
    end

    // write to r0 returns the value, read back is zero
    takeBits(`DATA_W, bits);
    runCommand(LDI, '0, '0, '0, bits[`DATA_W-1:0] | 16'h0001, 0);
    runCommand(ADD, '0, '0, '0, '0, 0);

    for (int n = 0; n < NUM_RANDOM; n++) begin
      takeBits(3, bits);
      op = opCodeT'(bits[2:0]);
      takeBits(3 * `REG_AW + 3, fields);
      takeBits(`DATA_W, bits);
      runCommand(op, fields[3*`REG_AW-1:2*`REG_AW], fields[2*`REG_AW-1:`REG_AW],
                 fields[`REG_AW-1:0], bits[`DATA_W-1:0],
                 int'(fields[3*`REG_AW+2:3*`REG_AW]));
    end

    $display("commands run: %0d, errors: %0d", cmdCount, errCount);
    if (errCount == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- execUnitTop.sv
`timescale 1ns/1ps
`include "regfile_defs.svh"
`default_nettype none

module execUnitTop (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 req,
  input  execPkg::opCodeT      opCode,
  input  logic [`REG_AW-1:0]   dstReg,
  input  logic [`REG_AW-1:0]   srcReg1,
  input  logic [`REG_AW-1:0]   srcReg2,
  input  logic [`DATA_W-1:0]   imm,
  output logic                 ack,
  output logic [`DATA_W-1:0]   result
);

  logic                 regWrite;
  logic                 shiftLoad;
  logic                 shiftStep;
  logic                 counterLoad;
  logic                 selSerial;
  logic                 resultCapture;
  logic                 countDone;
  logic [`DATA_W-1:0]   srcData1;
  logic [`DATA_W-1:0]   srcData2;
  logic [`DATA_W-1:0]   aluOut;
  logic [`DATA_W-1:0]   shiftOut;
  logic [`DATA_W-1:0]   writeData;

  opSequencer seq_i (
    .clk(clk), .rstN(rstN), .req(req), .opCode(opCode), .countDone(countDone),
    .ack(ack), .regWrite(regWrite), .shiftLoad(shiftLoad), .shiftStep(shiftStep),
    .counterLoad(counterLoad), .selSerial(selSerial), .resultCapture(resultCapture)
  );

  // shift amount comes from the low imm bits
  shiftCounter cnt_i (
    .clk(clk), .rstN(rstN), .counterLoad(counterLoad), .amount(imm[`SHAMT_W-1:0]),
    .countStep(shiftStep), .countDone(countDone)
  );

  serialShifter shf_i (
    .clk(clk), .rstN(rstN), .opCode(opCode), .shiftLoad(shiftLoad),
    .shiftStep(shiftStep), .operand(srcData1), .shiftOut(shiftOut)
  );

  aluUnit alu_i (
    .opCode(opCode), .operandA(srcData1), .operandB(srcData2), .imm(imm), .aluOut(aluOut)
  );

  registerFile rf_i (
    .clk(clk), .rstN(rstN), .srcReg1(srcReg1), .srcReg2(srcReg2), .dstReg(dstReg),
    .regWrite(regWrite), .writeData(writeData), .srcData1(srcData1), .srcData2(srcData2)
  );

  assign writeData = selSerial ? shiftOut : aluOut;

  // held for the requester while ack is up
  always_ff @(posedge clk) begin
    if (!rstN) begin
      result <= '0;
    end else if (resultCapture) begin
      result <= writeData;
    end
  end

endmodule

`default_nettype wire

//--- opSequencer.sv
`timescale 1ns/1ps
`include "regfile_defs.svh"
`default_nettype none

module opSequencer (
  input  logic              clk,
  input  logic              rstN,
  input  logic              req,
  input  execPkg::opCodeT   opCode,
  input  logic              countDone,
  output logic              ack,
  output logic              regWrite,
  output logic              shiftLoad,
  output logic              shiftStep,
  output logic              counterLoad,
  output logic              selSerial,
  output logic              resultCapture
);

  import execPkg::*;

  seqStateT state;
  seqStateT nextState;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= IDLE;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      IDLE: begin
        if (req) begin
          if ((opCode == SLL) || (opCode == SRA)) begin
            nextState = LOAD;
          end else begin
            nextState = EXEC;
          end
        end
      end
      EXEC: begin
        nextState = ACK;
      end
      LOAD: begin
        nextState = SHIFT;
      end
      // one bit per cycle until the counter runs out
      SHIFT: begin
        if (countDone) begin
          nextState = WRITE;
        end
      end
      WRITE: begin
        nextState = ACK;
      end
      ACK: begin
        if (!req) begin
          nextState = IDLE;
        end
      end
      default: begin
        nextState = IDLE;
      end
    endcase
  end

  // ack is registered, so it follows ACK entry by one cycle
  always_ff @(posedge clk) begin
    if (!rstN) begin
      ack <= 1'b0;
    end else begin
      ack <= (state == ACK) && req;
    end
  end

  assign regWrite      = (state == EXEC) || (state == WRITE);
  assign resultCapture = (state == EXEC) || (state == WRITE);
  assign shiftLoad     = (state == LOAD);
  assign counterLoad   = (state == LOAD);
  assign shiftStep     = (state == SHIFT) && !countDone;
  assign selSerial     = (state == WRITE);

  // four-phase rule, ack only drops once req is gone
  assertAckHold : assert property (
    @(posedge clk) disable iff (!rstN)
    $fell(ack) |-> !$past(req)
  );

endmodule

`default_nettype wire

//--- shiftCounter.sv
`timescale 1ns/1ps
`include "regfile_defs.svh"
`default_nettype none

module shiftCounter (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 counterLoad,
  input  logic [`SHAMT_W-1:0]  amount,
  input  logic                 countStep,
  output logic                 countDone
);

  logic [`SHAMT_W-1:0] count;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      count <= '0;
    end else if (counterLoad) begin
      count <= amount;
    end else if (countStep) begin
      count <= count - 1'b1;
    end
  end

  // zero amount is done straight after load
  assign countDone = (count == '0);

  assertNoUnderflow : assert property (
    @(posedge clk) disable iff (!rstN)
    countStep |-> (count != '0)
  );

endmodule

`default_nettype wire

//--- serialShifter.sv
`timescale 1ns/1ps
`include "regfile_defs.svh"
`default_nettype none

module serialShifter (
  input  logic                 clk,
  input  logic                 rstN,
  input  execPkg::opCodeT      opCode,
  input  logic                 shiftLoad,
  input  logic                 shiftStep,
  input  logic [`DATA_W-1:0]   operand,
  output logic [`DATA_W-1:0]   shiftOut
);

  import execPkg::*;

  logic [`DATA_W-1:0] shiftReg;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      shiftReg <= '0;
    end else if (shiftLoad) begin
      shiftReg <= operand;
    end else if (shiftStep) begin
      case (opCode)
        SLL: begin
          shiftReg <= {shiftReg[`DATA_W-2:0], 1'b0};
        end
        // sign bit copied in from the top
        SRA: begin
          shiftReg <= {shiftReg[`DATA_W-1], shiftReg[`DATA_W-1:1]};
        end
        default: begin
          shiftReg <= shiftReg;
        end
      endcase
    end
  end

  assign shiftOut = shiftReg;

  // sequencer never loads and steps in the same cycle
  assertLoadStep : assert property (
    @(posedge clk) disable iff (!rstN)
    !(shiftLoad && shiftStep)
  );

endmodule

`default_nettype wire

//--- aluUnit.sv
`timescale 1ns/1ps
`include "regfile_defs.svh"
`default_nettype none

module aluUnit (
  input  execPkg::opCodeT        opCode,
  input  logic [`DATA_W-1:0]     operandA,
  input  logic [`DATA_W-1:0]     operandB,
  input  logic [`DATA_W-1:0]     imm,
  output logic [`DATA_W-1:0]     aluOut
);

  import execPkg::*;

  // single step ops, wrap-around arithmetic
  always_comb begin
    case (opCode)
      ADD: begin
        aluOut = operandA + operandB;
      end
      SUB: begin
        aluOut = operandA - operandB;
      end
      AND: begin
        aluOut = operandA & operandB;
      end
      OR: begin
        aluOut = operandA | operandB;
      end
      XOR: begin
        aluOut = operandA ^ operandB;
      end
      LDI: begin
        aluOut = imm;
      end
      // shifts go through the serial shifter
      default: begin
        aluOut = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- registerFile.sv
`timescale 1ns/1ps
`include "regfile_defs.svh"
`default_nettype none

module registerFile (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic [`REG_AW-1:0]   srcReg1,
  input  logic [`REG_AW-1:0]   srcReg2,
  input  logic [`REG_AW-1:0]   dstReg,
  input  logic                 regWrite,
  input  logic [`DATA_W-1:0]   writeData,
  output logic [`DATA_W-1:0]   srcData1,
  output logic [`DATA_W-1:0]   srcData2
);

  // r0 has no storage, only r1 and up
  logic [`DATA_W-1:0] regs [1:`REG_COUNT-1];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 1; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (regWrite && (dstReg != '0)) begin
      regs[dstReg] <= writeData;
    end
  end

  // muxed read ports
  always_comb begin
    if (srcReg1 == '0) begin
      srcData1 = '0;
    end else begin
      srcData1 = regs[srcReg1];
    end
  end

  always_comb begin
    if (srcReg2 == '0) begin
      srcData2 = '0;
    end else begin
      srcData2 = regs[srcReg2];
    end
  end

  // r0 reads zero on either port
  assertZeroReg : assert property (
    @(posedge clk) disable iff (!rstN)
    (srcReg1 == '0) |-> (srcData1 == '0)
  );

  assertZeroReg2 : assert property (
    @(posedge clk) disable iff (!rstN)
    (srcReg2 == '0) |-> (srcData2 == '0)
  );

endmodule

`default_nettype wire

//--- execPkg.sv
`default_nettype none

package execPkg;

  // command opcodes as seen on the requester side
  typedef enum logic [2:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    LDI,
    SLL,
    SRA
  } opCodeT;

  typedef enum logic [2:0] {
    IDLE,
    EXEC,
    LOAD,
    SHIFT,
    WRITE,
    ACK
  } seqStateT;

endpackage

`default_nettype wire

//--- regfile_defs.svh
`ifndef REGFILE_DEFS_SVH
`define REGFILE_DEFS_SVH

// datapath and register file sizing
`define DATA_W 16
`define REG_AW 4
`define REG_COUNT 16
`define SHAMT_W 4

`endif
